// File: src/bpu_pkg.sv
// shared widths, table entries, correction/prediction structs and hash helpers; import into bpu modules
package bpu_pkg;

    // table geometry
    localparam int BTB_IDX_LEN = 9;                      // 512 rows per btb/bht bank
    localparam int TAG_LEN     = 8;                      // pc[19:12]
    localparam int HIST_LEN    = 5;                      // local history bits
    localparam int PHT_PC_LEN  = 8;                      // pc[10:3]
    localparam int PHT_IDX_LEN = HIST_LEN + PHT_PC_LEN;  // {history, pc bits}

    typedef enum logic [1:0] {
        BR_NORMAL = 2'd0,   // conditional
        BR_JUMP   = 2'd1,   // unconditional direct
        BR_CALL   = 2'd2,
        BR_RET    = 2'd3
    } br_type_e;

    typedef struct packed {
        logic [TAG_LEN-1:0] tag;
        logic [31:0]        target_pc;
        br_type_e           br_type;
        logic               is_branch;
    } btb_entry_t;

    typedef struct packed {
        logic [HIST_LEN-1:0] history;
    } bht_entry_t;

    typedef struct packed {
        logic [1:0] scnt;   // 2-bit saturating counter
    } pht_entry_t;

    // one backend correction
    typedef struct packed {
        logic                update;
        logic [31:0]         pc;
        logic [31:0]         target_pc;
        logic                is_branch;
        br_type_e            branch_type;
        logic                taken;
        logic                type_miss;
        logic                target_miss;
        logic [HIST_LEN-1:0] history;    // history seen at prediction
        logic [1:0]          scnt;       // counter seen at prediction
    } correct_info_t;

    // prediction for one slot
    typedef struct packed {
        logic [31:0]         target_pc;
        logic [31:0]         next_pc;
        logic                is_branch;
        br_type_e            br_type;
        logic                taken;
        logic [1:0]          scnt;
        logic                need_update;  // no btb entry for this pc
        logic [HIST_LEN-1:0] history;
    } predict_info_t;

    typedef struct packed {
        logic [31:0]              pc;
        logic [1:0]               mask;    // bit i set when slot i is live
        predict_info_t [1:0]      preds;
    } fetch_pkt_t;

    // btb/bht row index, two overlapping pc fields folded together
    function automatic logic [BTB_IDX_LEN-1:0] btb_hash(input logic [31:0] pc);
        return pc[17:9] ^ pc[11:3];
    endfunction

    function automatic logic [TAG_LEN-1:0] btb_tag(input logic [31:0] pc);
        return pc[TAG_LEN+11:12];
    endfunction

    // saturating 2-bit counter step
    function automatic logic [1:0] next_scnt(input logic [1:0] scnt, input logic taken);
        case (scnt)
            2'b00:   return {1'b0, taken};   // strong not taken
            2'b01:   return {taken, 1'b0};   // weak not taken
            2'b10:   return {taken, 1'b1};   // weak taken
            default: return {1'b1, taken};   // strong taken
        endcase
    endfunction

endpackage

// File: src/bpu_table.sv
// two-bank distributed-ram table with per-entry valid bits; shared by the btb, bht and pht
`timescale 1ns/1ps

module bpu_table #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 512
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [1:0][$clog2(DEPTH)-1:0]  raddr_i,   // one row per bank
    input  logic                           we_i,
    input  logic                           wbank_i,
    input  logic [$clog2(DEPTH)-1:0]       waddr_i,
    input  entry_t                         wdata_i,
    output entry_t [1:0]                   rdata_o,
    output logic [1:0]                     rvalid_o
);

    entry_t             mem_q [2][DEPTH];   // data only, maps to lutram
    logic [1:0][DEPTH-1:0] vld_q;           // row written since reset

    // async read, bank b serves slot b
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            rdata_o[b]  = mem_q[b][raddr_i[b]];
            rvalid_o[b] = vld_q[b][raddr_i[b]];
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[wbank_i][waddr_i] <= wdata_i;   // one bank per cycle
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;                          // every row invalid
        end else if (we_i) begin
            vld_q[wbank_i][waddr_i] <= 1'b1;
        end
    end

endmodule

// File: src/bpu_correct_sel.sv
// decode stage: picks one backend correction and turns it into btb/bht/pht/ras write commands
`timescale 1ns/1ps

module bpu_correct_sel (
    input  bpu_pkg::correct_info_t [1:0]      corrections_i,
    // btb, bank and row shared with bht
    output logic                              btb_we_o,
    output logic                              bank_o,
    output logic [bpu_pkg::BTB_IDX_LEN-1:0]   btb_waddr_o,
    output bpu_pkg::btb_entry_t               btb_wdata_o,
    // bht
    output logic                              bht_we_o,
    output bpu_pkg::bht_entry_t               bht_wdata_o,
    // pht
    output logic                              pht_we_o,
    output logic [bpu_pkg::PHT_IDX_LEN-1:0]   pht_waddr_o,
    output bpu_pkg::pht_entry_t               pht_wdata_o,
    // ras
    output logic                              ras_push_o,
    output logic                              ras_pop_o,
    output logic [31:0]                       ras_push_pc_o
);
    import bpu_pkg::*;

    correct_info_t sel;   // first correction with update set
    logic          upd;

    // slot 0 first, else slot 1; if 1 has no update either, nothing is written
    assign sel = corrections_i[0].update ? corrections_i[0] : corrections_i[1];
    assign upd = sel.update;

    assign bank_o      = sel.pc[2];          // odd word lives in bank 1
    assign btb_waddr_o = btb_hash(sel.pc);

    // btb only learns on a type or target miss
    assign btb_we_o              = upd & (sel.type_miss | sel.target_miss);
    assign btb_wdata_o.tag       = btb_tag(sel.pc);
    assign btb_wdata_o.target_pc = sel.target_pc;
    assign btb_wdata_o.br_type   = sel.branch_type;
    assign btb_wdata_o.is_branch = sel.is_branch;

    // new branch restarts history with just this outcome
    assign bht_we_o = upd;
    assign bht_wdata_o.history = sel.type_miss ? {{(HIST_LEN-1){1'b0}}, sel.taken}
                                               : {sel.history[HIST_LEN-2:0], sel.taken};

    // pht indexed by history seen at predict time
    assign pht_we_o         = upd;
    assign pht_waddr_o      = {sel.history, sel.pc[PHT_PC_LEN+2:3]};
    assign pht_wdata_o.scnt = next_scnt(sel.scnt, sel.taken);

    // stack follows backend calls/returns only
    assign ras_push_o    = upd & (sel.branch_type == BR_CALL);
    assign ras_pop_o     = upd & (sel.branch_type == BR_RET);
    assign ras_push_pc_o = sel.pc + 32'd4;   // return lands after the call

endmodule

// File: src/bpu_ras.sv
// circular return address stack, pushed on call corrections and popped on return corrections
`timescale 1ns/1ps

module bpu_ras #(
    parameter int RAS_DEPTH = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] push_pc_i,
    output logic [31:0] top_o
);

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

    logic [31:0]      stk_q [RAS_DEPTH];   // return addresses
    logic [PTR_W-1:0] top_q;               // newest entry
    logic [PTR_W-1:0] wr_q;                // next free slot

    assign top_o = stk_q[top_q];

    // overflow simply wraps onto the oldest entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= '1;                   // empty
            wr_q  <= '0;
        end else if (push_i) begin
            top_q <= wr_q;
            wr_q  <= wr_q + 1'b1;
        end else if (pop_i) begin
            wr_q  <= top_q;                // popped slot reused by next push
            top_q <= top_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stk_q[wr_q] <= push_pc_i;
        end
    end

endmodule

// File: src/bpu_lookup.sv
// execute stage: reads btb, bht, pht and ras for both slots and forms per-slot predictions
`timescale 1ns/1ps

module bpu_lookup #(
    parameter int RAS_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [31:0]                       pc_i,
    input  logic                              btb_we_i,
    input  logic                              bank_i,
    input  logic [bpu_pkg::BTB_IDX_LEN-1:0]   btb_waddr_i,
    input  bpu_pkg::btb_entry_t               btb_wdata_i,
    input  logic                              bht_we_i,
    input  bpu_pkg::bht_entry_t               bht_wdata_i,
    input  logic                              pht_we_i,
    input  logic [bpu_pkg::PHT_IDX_LEN-1:0]   pht_waddr_i,
    input  bpu_pkg::pht_entry_t               pht_wdata_i,
    input  logic                              ras_push_i,
    input  logic                              ras_pop_i,
    input  logic [31:0]                       ras_push_pc_i,
    output bpu_pkg::predict_info_t [1:0]      preds_o
);
    import bpu_pkg::*;

    logic [BTB_IDX_LEN-1:0]      row;
    logic [1:0][BTB_IDX_LEN-1:0] row_pair;    // same row in both banks
    btb_entry_t [1:0]            btb_rd;
    logic [1:0]                  btb_vld;
    btb_entry_t [1:0]            btb_e;       // invalid rows read as zero
    bht_entry_t [1:0]            bht_rd;
    logic [1:0]                  bht_vld;
    logic [1:0][HIST_LEN-1:0]    hist;
    logic [1:0][PHT_IDX_LEN-1:0] pht_raddr;   // differs per slot
    pht_entry_t [1:0]            pht_rd;
    logic [1:0]                  pht_vld;
    logic [1:0][1:0]             scnt;
    logic [1:0]                  tag_match;
    logic [1:0]                  hit;
    logic [1:0]                  branch;
    logic [31:0]                 ras_top;

    assign row      = btb_hash(pc_i);
    assign row_pair = {row, row};

    bpu_table #(.entry_t(btb_entry_t), .DEPTH(2 ** BTB_IDX_LEN)) u_btb (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr_i  (row_pair),
        .we_i     (btb_we_i),
        .wbank_i  (bank_i),
        .waddr_i  (btb_waddr_i),
        .wdata_i  (btb_wdata_i),
        .rdata_o  (btb_rd),
        .rvalid_o (btb_vld)
    );

    // bht rides on the btb write row
    bpu_table #(.entry_t(bht_entry_t), .DEPTH(2 ** BTB_IDX_LEN)) u_bht (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr_i  (row_pair),
        .we_i     (bht_we_i),
        .wbank_i  (bank_i),
        .waddr_i  (btb_waddr_i),
        .wdata_i  (bht_wdata_i),
        .rdata_o  (bht_rd),
        .rvalid_o (bht_vld)
    );

    bpu_table #(.entry_t(pht_entry_t), .DEPTH(2 ** PHT_IDX_LEN)) u_pht (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr_i  (pht_raddr),
        .we_i     (pht_we_i),
        .wbank_i  (bank_i),
        .waddr_i  (pht_waddr_i),
        .wdata_i  (pht_wdata_i),
        .rdata_o  (pht_rd),
        .rvalid_o (pht_vld)
    );

    bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_i    (ras_push_i),
        .pop_i     (ras_pop_i),
        .push_pc_i (ras_push_pc_i),
        .top_o     (ras_top)
    );

    // first level, btb/bht read and pht index
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            btb_e[i]     = btb_vld[i] ? btb_rd[i] : '0;
            hist[i]      = bht_vld[i] ? bht_rd[i].history : '0;
            pht_raddr[i] = {hist[i], pc_i[PHT_PC_LEN+2:3]};
        end
    end

    // second level, tag check and branch decision
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            scnt[i]      = pht_vld[i] ? pht_rd[i].scnt : 2'b00;   // untrained = strong nt
            tag_match[i] = btb_vld[i] && (btb_e[i].tag == btb_tag(pc_i));
            hit[i]       = tag_match[i] && btb_e[i].is_branch;
            // unconditional types always go, conditionals follow counter msb
            branch[i]    = hit[i] && (btb_e[i].br_type != BR_NORMAL || scnt[i][1]);

            preds_o[i].target_pc   = (btb_e[i].br_type == BR_RET) ? ras_top
                                                                  : btb_e[i].target_pc;
            preds_o[i].next_pc     = '0;                 // result stage fills this
            preds_o[i].is_branch   = hit[i];
            preds_o[i].br_type     = btb_e[i].br_type;
            preds_o[i].taken       = branch[i];
            preds_o[i].scnt        = scnt[i];
            preds_o[i].need_update = !tag_match[i];      // ask backend to install
            preds_o[i].history     = hist[i];
        end
    end

endmodule

// File: src/bpu_next_pc.sv
// result stage: owns the fetch pc and valid, picks the next pc and builds the fetch packet
`timescale 1ns/1ps

module bpu_next_pc #(
    parameter logic [31:0] INIT_PC = 32'h1c00_0000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic [31:0]                   redir_pc_i,
    input  logic                          ready_i,
    input  bpu_pkg::predict_info_t [1:0]  preds_i,
    output logic [31:0]                   pc_o,
    output bpu_pkg::fetch_pkt_t           fetch_pkt_o,
    output logic                          valid_o
);
    import bpu_pkg::*;

    logic [31:0]      pc_q;
    logic [31:0]      pc_d;
    logic             valid_q;
    logic [31:0]      pc_add_8;      // start of next aligned group
    logic [1:0][31:0] slot_next;
    logic [1:0]       mask;

    assign pc_add_8 = {pc_q[31:3] + 29'd1, 3'b000};

    // per-slot fall-through or target
    assign slot_next[0] = preds_i[0].taken ? preds_i[0].target_pc : {pc_q[31:3], 3'b100};
    assign slot_next[1] = preds_i[1].taken ? preds_i[1].target_pc : pc_add_8;

    // slot 0 dead on odd entry, slot 1 dead after a taken slot 0
    assign mask = {!preds_i[0].taken | pc_q[2], !pc_q[2]};

    always_comb begin
        pc_d = pc_add_8;
        if (preds_i[0].taken && !pc_q[2]) begin
            pc_d = slot_next[0];              // slot 0 wins when live
        end else if (preds_i[1].taken) begin
            pc_d = slot_next[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= INIT_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;                  // lookup always done in one cycle
            if (flush_i) begin
                pc_q <= redir_pc_i;           // redirect beats handshake
            end else if (valid_q && ready_i) begin
                pc_q <= pc_d;
            end
        end
    end

    always_comb begin
        fetch_pkt_o.pc    = pc_q;
        fetch_pkt_o.mask  = mask;
        fetch_pkt_o.preds = preds_i;
        for (int i = 0; i < 2; i++) begin
            fetch_pkt_o.preds[i].next_pc = slot_next[i];
        end
    end

    assign pc_o    = pc_q;
    assign valid_o = valid_q;

endmodule

// File: src/bpu.sv
// branch prediction front end top: correction decode, table lookup and next-pc stages
`timescale 1ns/1ps

module bpu #(
    parameter logic [31:0] INIT_PC   = 32'h1c00_0000,
    parameter int          RAS_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic [31:0]                   redir_pc_i,
    input  bpu_pkg::correct_info_t [1:0]  corrections_i,   // backend feedback
    input  logic                          ready_i,
    output bpu_pkg::fetch_pkt_t           fetch_pkt_o,
    output logic                          valid_o
);
    import bpu_pkg::*;

    // correction write controls
    logic                   btb_we;
    logic                   bank;
    logic [BTB_IDX_LEN-1:0] btb_waddr;
    btb_entry_t             btb_wdata;
    logic                   bht_we;
    bht_entry_t             bht_wdata;
    logic                   pht_we;
    logic [PHT_IDX_LEN-1:0] pht_waddr;
    pht_entry_t             pht_wdata;
    logic                   ras_push;
    logic                   ras_pop;
    logic [31:0]            ras_push_pc;

    logic [31:0]            pc;      // fetch pc from result stage
    predict_info_t [1:0]    preds;

    bpu_correct_sel u_correct_sel (
        .corrections_i (corrections_i),
        .btb_we_o      (btb_we),
        .bank_o        (bank),
        .btb_waddr_o   (btb_waddr),
        .btb_wdata_o   (btb_wdata),
        .bht_we_o      (bht_we),
        .bht_wdata_o   (bht_wdata),
        .pht_we_o      (pht_we),
        .pht_waddr_o   (pht_waddr),
        .pht_wdata_o   (pht_wdata),
        .ras_push_o    (ras_push),
        .ras_pop_o     (ras_pop),
        .ras_push_pc_o (ras_push_pc)
    );

    bpu_lookup #(.RAS_DEPTH(RAS_DEPTH)) u_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_i          (pc),
        .btb_we_i      (btb_we),
        .bank_i        (bank),
        .btb_waddr_i   (btb_waddr),
        .btb_wdata_i   (btb_wdata),
        .bht_we_i      (bht_we),
        .bht_wdata_i   (bht_wdata),
        .pht_we_i      (pht_we),
        .pht_waddr_i   (pht_waddr),
        .pht_wdata_i   (pht_wdata),
        .ras_push_i    (ras_push),
        .ras_pop_i     (ras_pop),
        .ras_push_pc_i (ras_push_pc),
        .preds_o       (preds)
    );

    bpu_next_pc #(.INIT_PC(INIT_PC)) u_next_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .redir_pc_i  (redir_pc_i),
        .ready_i     (ready_i),
        .preds_i     (preds),
        .pc_o        (pc),
        .fetch_pkt_o (fetch_pkt_o),
        .valid_o     (valid_o)
    );

endmodule

// File: test/bpu_tb.sv
// directed testbench for the bpu front end; run the bpu_tb top with the vlog.f file list
`timescale 1ns/1ps

module bpu_tb;
    import bpu_pkg::*;

    localparam logic [31:0] INIT_PC = 32'h1c00_0000;
    localparam int RESET_CYCLES = 8;
    // cycle budget per test in run order
    localparam int TEST_CYCLES  = 4 + 8 + 4 + 5 + 20 + 6 + 8;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + 32;   // plus margin

    logic                clk;
    logic                rst_n;
    logic                flush_i;
    logic [31:0]         redir_pc_i;
    correct_info_t [1:0] corrections_i;
    logic                ready_i;
    fetch_pkt_t          fetch_pkt_o;
    logic                valid_o;

    int n_checks = 0;
    int n_errors = 0;
    int n_tests  = 0;
    int cycles   = 0;
    logic [511:0] used_row;        // btb rows already handed out
    logic [255:0] used_lo;         // pc[10:3] values already handed out
    logic [1:0]   pht_m [8192];    // counter model for bank 0

    bpu #(.INIT_PC(INIT_PC), .RAS_DEPTH(8)) bpu_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .redir_pc_i    (redir_pc_i),
        .corrections_i (corrections_i),
        .ready_i       (ready_i),
        .fetch_pkt_o   (fetch_pkt_o),
        .valid_o       (valid_o)
    );

    always #5 clk = ~clk;   // 10 ns period

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // drive point 1 ns past the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic flush_to(input logic [31:0] pc);
        flush_i    = 1'b1;
        redir_pc_i = pc;
        tick();
        flush_i    = 1'b0;
    endtask

    task automatic check_pkt(input string what, input fetch_pkt_t got, input fetch_pkt_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED fetch_pkt_o (%s): got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_pred(input string what, input int slot, input predict_info_t got,
                              input predict_info_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED fetch_pkt_o.preds[%0d] (%s): got %h expected %h",
                     slot, what, got, exp);
        end
    endtask

    task automatic check_pc(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED fetch_pkt_o.pc (%s): got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_valid(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED valid_o (%s): got %h expected %h", what, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        n_tests++;
        $display("test %-22s done, %0d errors", name, n_errors - errs_before);
    endtask

    // 2-bit saturating counter from the transition table
    function automatic logic [1:0] counter_step(input logic [1:0] s, input logic taken);
        if (taken) begin
            return (s == 2'b11) ? 2'b11 : s + 2'b01;
        end
        return (s == 2'b00) ? 2'b00 : s - 2'b01;
    endfunction

    // random group pc whose btb row and pht pc bits no earlier test used
    function automatic logic [31:0] fresh_pc(input logic odd);
        logic [31:0] pc;
        logic [8:0]  row;
        do begin
            pc  = ($urandom & 32'hffff_fff8) | {29'd0, odd, 2'b00};
            row = pc[17:9] ^ pc[11:3];
        end while (used_row[row] || used_lo[pc[10:3]]);
        used_row[row]     = 1'b1;
        used_lo[pc[10:3]] = 1'b1;
        return pc;
    endfunction

    function automatic correct_info_t make_corr(
        input logic [31:0] pc, input logic [31:0] tgt, input br_type_e bt,
        input logic taken, input logic type_miss, input logic target_miss,
        input logic [HIST_LEN-1:0] hist, input logic [1:0] scnt);
        correct_info_t c;
        c             = '0;
        c.update      = 1'b1;
        c.pc          = pc;
        c.target_pc   = tgt;
        c.is_branch   = 1'b1;
        c.branch_type = bt;
        c.taken       = taken;
        c.type_miss   = type_miss;
        c.target_miss = target_miss;
        c.history     = hist;
        c.scnt        = scnt;
        return c;
    endfunction

    // slot with no btb entry where empty tables read as zero
    function automatic predict_info_t miss_pred();
        predict_info_t p;
        p             = '0;
        p.need_update = 1'b1;
        return p;
    endfunction

    function automatic predict_info_t hit_pred(input logic [31:0] tgt, input br_type_e bt,
                                               input logic [1:0] scnt,
                                               input logic [HIST_LEN-1:0] hist);
        predict_info_t p;
        p           = '0;
        p.target_pc = tgt;
        p.is_branch = 1'b1;
        p.br_type   = bt;
        p.scnt      = scnt;
        p.history   = hist;
        p.taken     = (bt != BR_NORMAL) || scnt[1];   // conditionals follow the msb
        return p;
    endfunction

    // fills slot next pcs and mask around two slot predictions
    function automatic fetch_pkt_t build_pkt(input logic [31:0] pc, input predict_info_t p0,
                                             input predict_info_t p1);
        fetch_pkt_t pk;
        pk.pc               = pc;
        pk.mask             = {!p0.taken || pc[2], !pc[2]};
        pk.preds[0]         = p0;
        pk.preds[0].next_pc = p0.taken ? p0.target_pc : {pc[31:3], 3'b100};
        pk.preds[1]         = p1;
        pk.preds[1].next_pc = p1.taken ? p1.target_pc : {pc[31:3], 3'b000} + 32'd8;
        return pk;
    endfunction

    task automatic test_reset_seq();
        int          e0;
        logic [31:0] pc;
        e0 = n_errors;
        pc = INIT_PC;
        check_pkt("after reset", fetch_pkt_o, build_pkt(pc, miss_pred(), miss_pred()));
        ready_i = 1'b1;
        for (int k = 0; k < 3; k++) begin
            tick();                                 // one transfer per edge
            pc = {pc[31:3], 3'b000} + 32'd8;
            check_pkt("sequential", fetch_pkt_o, build_pkt(pc, miss_pred(), miss_pred()));
        end
        ready_i = 1'b0;
        for (int k = 0; k < 2; k++) begin
            tick();
            check_pkt("hold, ready low", fetch_pkt_o, build_pkt(pc, miss_pred(), miss_pred()));
            check_valid("hold, ready low", valid_o, 1'b1);
        end
        end_test("reset_seq", e0);
    endtask

    task automatic test_flush();
        int          e0;
        logic [31:0] pa;
        logic [31:0] pb;
        e0      = n_errors;
        pa      = fresh_pc(1'b1);   // odd slot entry
        pb      = fresh_pc(1'b0);
        ready_i = 1'b1;             // flush must win over the live handshake
        flush_to(pa);
        check_pkt("odd redirect", fetch_pkt_o, build_pkt(pa, miss_pred(), miss_pred()));
        flush_to(pb);
        check_pkt("flush over handshake", fetch_pkt_o, build_pkt(pb, miss_pred(), miss_pred()));
        ready_i = 1'b0;
        end_test("flush", e0);
    endtask

    task automatic test_jump();
        int          e0;
        logic [31:0] pc_j;
        logic [31:0] tgt;
        e0   = n_errors;
        pc_j = fresh_pc(1'b0);
        tgt  = $urandom & 32'hffff_fffc;
        // element 0 idle so element 1 applies
        corrections_i[1] = make_corr(pc_j, tgt, BR_JUMP, 1'b1, 1'b0, 1'b1, '0, 2'b00);
        tick();
        corrections_i = '0;
        flush_to(pc_j);
        // cleared history shifted by one taken bit with the pht row still untrained
        check_pkt("jump lookup", fetch_pkt_o,
                  build_pkt(pc_j, hit_pred(tgt, BR_JUMP, 2'b00, 5'b00001), miss_pred()));
        ready_i = 1'b1;
        tick();
        ready_i = 1'b0;
        check_pc("after jump", fetch_pkt_o.pc, tgt);
        end_test("jump", e0);
    endtask

    task automatic test_counter();
        int                     e0;
        logic [31:0]            pc_c;
        logic [31:0]            tgt;
        logic [HIST_LEN-1:0]    hist_m;
        logic [PHT_IDX_LEN-1:0] idx;
        logic                   outcome;
        fetch_pkt_t             exp;
        e0   = n_errors;
        pc_c = fresh_pc(1'b0);
        tgt  = $urandom & 32'hffff_fffc;
        foreach (pht_m[i]) begin
            pht_m[i] = 2'b00;
        end
        // install on a type miss while redirecting to it
        corrections_i[0] = make_corr(pc_c, tgt, BR_NORMAL, 1'b1, 1'b1, 1'b0, 5'b10110, 2'b00);
        pht_m[{5'b10110, pc_c[10:3]}] = counter_step(2'b00, 1'b1);
        hist_m = 5'b00001;                      // type miss drops the stale history
        flush_to(pc_c);
        corrections_i = '0;
        for (int step = 0; step < 16; step++) begin
            idx = {hist_m, pc_c[10:3]};
            exp = build_pkt(pc_c, hit_pred(tgt, BR_NORMAL, pht_m[idx], hist_m), miss_pred());
            check_pred("counter training", 0, fetch_pkt_o.preds[0], exp.preds[0]);
            outcome = (step != 9);              // saturated row steps down, seen again at 15
            corrections_i[0] = make_corr(pc_c, tgt, BR_NORMAL, outcome, 1'b0, 1'b0,
                                         hist_m, pht_m[idx]);
            pht_m[idx] = counter_step(pht_m[idx], outcome);
            hist_m     = {hist_m[HIST_LEN-2:0], outcome};
            tick();
            corrections_i = '0;
        end
        end_test("counter", e0);
    endtask

    task automatic test_call_ret();
        int          e0;
        logic [31:0] pc_r;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        fetch_pkt_t  exp;
        e0   = n_errors;
        pc_r = fresh_pc(1'b0);
        pc_a = fresh_pc(1'b0);
        pc_b = fresh_pc(1'b1);
        // installing the return also pops the still empty stack
        corrections_i[0] = make_corr(pc_r, '0, BR_RET, 1'b1, 1'b1, 1'b0, '0, 2'b00);
        tick();
        corrections_i[0] = make_corr(pc_a, pc_r, BR_CALL, 1'b1, 1'b0, 1'b0, '0, 2'b00);
        tick();
        corrections_i[0] = make_corr(pc_b, pc_r, BR_CALL, 1'b1, 1'b0, 1'b0, '0, 2'b00);
        flush_to(pc_r);
        corrections_i = '0;
        exp = build_pkt(pc_r, hit_pred(pc_b + 32'd4, BR_RET, 2'b00, 5'b00001), miss_pred());
        check_pred("return to newest call", 0, fetch_pkt_o.preds[0], exp.preds[0]);
        // return retires so the older call surfaces
        corrections_i[0] = make_corr(pc_r, '0, BR_RET, 1'b1, 1'b0, 1'b0, 5'b00001, 2'b00);
        tick();
        corrections_i = '0;
        exp = build_pkt(pc_r, hit_pred(pc_a + 32'd4, BR_RET, 2'b00, 5'b00011), miss_pred());
        check_pred("return after pop", 0, fetch_pkt_o.preds[0], exp.preds[0]);
        end_test("call_ret", e0);
    endtask

    task automatic test_two_slot();
        int          e0;
        logic [31:0] p;
        logic [31:0] t0;
        logic [31:0] t1;
        e0 = n_errors;
        p  = fresh_pc(1'b0);
        t0 = $urandom & 32'hffff_fffc;
        t1 = $urandom & 32'hffff_fffc;
        corrections_i[0] = make_corr(p, t0, BR_JUMP, 1'b1, 1'b1, 1'b0, '0, 2'b00);
        corrections_i[1] = make_corr(p | 32'd4, t1, BR_JUMP, 1'b1, 1'b1, 1'b0, '0, 2'b00);
        tick();                                  // element 1 waits its turn
        corrections_i[0] = '0;
        tick();
        corrections_i = '0;
        flush_to(p);
        check_pkt("even entry", fetch_pkt_o,
                  build_pkt(p, hit_pred(t0, BR_JUMP, 2'b00, 5'b00001),
                            hit_pred(t1, BR_JUMP, 2'b00, 5'b00001)));
        ready_i = 1'b1;
        tick();
        ready_i = 1'b0;
        check_pc("slot 0 wins", fetch_pkt_o.pc, t0);
        flush_to(p | 32'd4);
        check_pkt("odd entry", fetch_pkt_o,
                  build_pkt(p | 32'd4, hit_pred(t0, BR_JUMP, 2'b00, 5'b00001),
                            hit_pred(t1, BR_JUMP, 2'b00, 5'b00001)));
        ready_i = 1'b1;
        tick();
        ready_i = 1'b0;
        check_pc("slot 1 wins", fetch_pkt_o.pc, t1);
        end_test("two_slot", e0);
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (!valid_o && n < 4) begin
            tick();
            n++;
        end
        if (!valid_o) begin
            n_errors++;
            $display("valid_o did not rise after reset release");
        end else if (n != 1) begin
            n_errors++;
            $display("valid_o rose %0d cycles after reset release instead of one", n);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        redir_pc_i    = '0;
        corrections_i = '0;
        ready_i       = 1'b0;
        used_row      = '0;
        used_lo       = '0;
        void'($urandom(60));
        repeat (RESET_CYCLES) tick();
        check_valid("in reset", valid_o, 1'b0);
        rst_n = 1'b1;
        wait_valid();

        test_reset_seq();
        test_flush();
        test_jump();
        test_counter();
        test_call_ret();
        test_two_slot();

        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/bpu_pkg.sv
src/bpu_table.sv
src/bpu_correct_sel.sv
src/bpu_ras.sv
src/bpu_lookup.sv
src/bpu_next_pc.sv
src/bpu.sv
test/bpu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := bpu_tb
RTL_TOP    := bpu
FILELIST   := vlog.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
